//--- pdh_pkg.sv
package pdh_pkg;

    ////////////////////////////////////////////////////////////
    // Field widths
    ////////////////////////////////////////////////////////////
    localparam int unsigned GPIO_W   = 32;
    localparam int unsigned CMD_W    = 4;
    localparam int unsigned DATA_W   = 26;
    localparam int unsigned ADC_W    = 14;
    localparam int unsigned SAMPLE_W = 16;
    localparam int unsigned DAC_W    = 14;
    localparam int unsigned LED_W    = 8;
    localparam int unsigned CS_SEL_W = 5;

    typedef logic        [GPIO_W-1:0]   gpio_word_t;
    typedef logic        [DATA_W-1:0]   cmd_data_t;
    typedef logic        [ADC_W-1:0]    adc_raw_t;
    typedef logic signed [SAMPLE_W-1:0] sample_t;  // Q1.15 for coefficients
    typedef logic        [DAC_W-1:0]    dac_code_t;
    typedef logic        [LED_W-1:0]    led_t;
    typedef logic        [CS_SEL_W-1:0] cs_sel_t;

    // Codes 7..15 are not listed and act as a full restore
    typedef enum logic [CMD_W-1:0] {
        CMD_IDLE              = 4'd0,
        CMD_SET_LED           = 4'd1,
        CMD_SET_DAC           = 4'd2,
        CMD_GET_ADC           = 4'd3,
        CMD_CHECK_SIGNED      = 4'd4,
        CMD_SET_ROT_COEFFS    = 4'd5,
        CMD_COMMIT_ROT_COEFFS = 4'd6
    } cmd_t;

    ////////////////////////////////////////////////////////////
    // GPIO word layout
    ////////////////////////////////////////////////////////////
    localparam int unsigned STROBE_BIT = 30;
    localparam int unsigned CMD_MSB    = 29;
    localparam int unsigned CMD_LSB    = 26;
    localparam int unsigned CB_CMD_LSB = 28;  // Echoed command in callback

    ////////////////////////////////////////////////////////////
    // Datapath constants
    ////////////////////////////////////////////////////////////
    localparam sample_t   ADC_OFFSET   = 16'sd8192;  // Mid-scale of 14 bit ADC
    localparam sample_t   COEFF_ONE    = 16'sh7FFF;
    localparam dac_code_t DAC_MIDSCALE = 14'h2000;
    localparam int unsigned COEFF_SHIFT = 15;

endpackage

//--- gpio_cmd_sync.sv
`timescale 1ns/1ps

module gpio_cmd_sync #(
    parameter int unsigned SYNC_STAGES = 2
) (
    input  logic                clk,
    input  logic                rst_i,
    input  pdh_pkg::gpio_word_t gpio_i,
    output pdh_pkg::cmd_t       cmd_o,
    output pdh_pkg::cmd_data_t  data_o
);
    import pdh_pkg::*;

    logic [SYNC_STAGES-1:0] sync_r;
    logic                   strobe_d_r;
    logic                   strobe_rise_w;
    gpio_word_t             word_r;

    ////////////////////////////////////////////////////////////
    // Strobe synchronizer and edge detect
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            sync_r     <= '0;
            strobe_d_r <= 1'b0;
        end else begin
            sync_r     <= {sync_r[SYNC_STAGES-2:0], gpio_i[STROBE_BIT]};
            strobe_d_r <= sync_r[SYNC_STAGES-1];
        end
    end

    assign strobe_rise_w = sync_r[SYNC_STAGES-1] & ~strobe_d_r;

    // Word stays in force until the next strobe
    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            word_r <= '0;  // Decodes as IDLE
        end else if (strobe_rise_w) begin
            word_r <= gpio_i;
        end
    end

    assign cmd_o  = cmd_t'(word_r[CMD_MSB:CMD_LSB]);
    assign data_o = word_r[CMD_LSB-1:0];

endmodule

//--- cmd_regs.sv
`timescale 1ns/1ps

module cmd_regs (
    input  logic               clk,
    input  logic               rst_i,
    input  pdh_pkg::cmd_t      cmd_i,
    input  pdh_pkg::cmd_data_t data_i,
    output pdh_pkg::led_t      led_o,
    output pdh_pkg::dac_code_t dac_dat_o,
    output logic               dac_sel_o,
    output logic               dac_wrt_o,
    output pdh_pkg::sample_t   sin_o,
    output pdh_pkg::sample_t   cos_o,
    output pdh_pkg::sample_t   rot_sin_o,
    output pdh_pkg::sample_t   rot_cos_o
);
    import pdh_pkg::*;

    led_t      led_r, next_led_w;
    sample_t   sin_r, next_sin_w;
    sample_t   cos_r, next_cos_w;
    sample_t   rot_sin_r, next_rot_sin_w;
    sample_t   rot_cos_r, next_rot_cos_w;
    dac_code_t dac_dat_r, next_dac_dat_w;
    logic      dac_sel_r, next_dac_sel_w;
    logic      dac_wrt_r, next_dac_wrt_w;

    ////////////////////////////////////////////////////////////
    // Next state from the latched command
    ////////////////////////////////////////////////////////////
    always_comb begin
        next_led_w     = led_r;
        next_sin_w     = sin_r;
        next_cos_w     = cos_r;
        next_rot_sin_w = rot_sin_r;
        next_rot_cos_w = rot_cos_r;
        next_dac_dat_w = dac_dat_r;
        next_dac_sel_w = dac_sel_r;
        next_dac_wrt_w = dac_wrt_r;

        case (cmd_i)
            CMD_IDLE, CMD_GET_ADC, CMD_CHECK_SIGNED: begin
                // Readback only
            end
            CMD_SET_LED: next_led_w = data_i[7:0];
            CMD_SET_DAC: begin
                next_dac_wrt_w = data_i[15];
                next_dac_sel_w = data_i[14];
                next_dac_dat_w = data_i[13:0];
            end
            CMD_SET_ROT_COEFFS: begin
                if (data_i[16]) begin
                    next_sin_w = data_i[15:0];
                end else begin
                    next_cos_w = data_i[15:0];
                end
            end
            CMD_COMMIT_ROT_COEFFS: begin
                next_rot_sin_w = sin_r;
                next_rot_cos_w = cos_r;
            end
            default: begin  // Undefined codes restore everything
                next_led_w     = '0;
                next_sin_w     = '0;
                next_cos_w     = COEFF_ONE;
                next_rot_sin_w = '0;
                next_rot_cos_w = COEFF_ONE;
                next_dac_dat_w = DAC_MIDSCALE;
                next_dac_sel_w = 1'b0;
                next_dac_wrt_w = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            led_r     <= '0;
            sin_r     <= '0;
            cos_r     <= COEFF_ONE;
            rot_sin_r <= '0;
            rot_cos_r <= COEFF_ONE;
            dac_dat_r <= DAC_MIDSCALE;
            dac_sel_r <= 1'b0;
            dac_wrt_r <= 1'b0;
        end else begin
            led_r     <= next_led_w;
            sin_r     <= next_sin_w;
            cos_r     <= next_cos_w;
            rot_sin_r <= next_rot_sin_w;
            rot_cos_r <= next_rot_cos_w;
            dac_dat_r <= next_dac_dat_w;
            dac_sel_r <= next_dac_sel_w;
            dac_wrt_r <= next_dac_wrt_w;
        end
    end

    ////////////////////////////////////////////////////////////
    // DAC outputs move half a cycle later
    ////////////////////////////////////////////////////////////
    always_ff @(negedge clk or posedge rst_i) begin
        if (rst_i) begin
            dac_dat_o <= DAC_MIDSCALE;
            dac_sel_o <= 1'b0;
            dac_wrt_o <= 1'b0;
        end else begin
            dac_dat_o <= dac_dat_r;
            dac_sel_o <= dac_sel_r;
            dac_wrt_o <= dac_wrt_r;
        end
    end

    assign led_o     = led_r;
    assign sin_o     = sin_r;
    assign cos_o     = cos_r;
    assign rot_sin_o = rot_sin_r;
    assign rot_cos_o = rot_cos_r;

endmodule

//--- adc_conditioner.sv
`timescale 1ns/1ps

module adc_conditioner (
    input  logic              clk,
    input  logic              rst_i,
    input  pdh_pkg::adc_raw_t adc_a_i,
    input  pdh_pkg::adc_raw_t adc_b_i,
    output pdh_pkg::sample_t  a_o,
    output pdh_pkg::sample_t  b_o
);
    import pdh_pkg::*;

    // Offset removal with inversion, front end is inverting
    function automatic sample_t condition(adc_raw_t raw);
        sample_t code_s;
        code_s = sample_t'({2'b00, raw});
        return ADC_OFFSET - code_s;
    endfunction

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            a_o <= '0;
            b_o <= '0;
        end else begin
            a_o <= condition(adc_a_i);
            b_o <= condition(adc_b_i);
        end
    end

endmodule

//--- iq_rotator.sv
`timescale 1ns/1ps

module iq_rotator (
    input  logic             clk,
    input  logic             rst_i,
    input  pdh_pkg::sample_t a_i,
    input  pdh_pkg::sample_t b_i,
    input  pdh_pkg::sample_t rot_cos_i,
    input  pdh_pkg::sample_t rot_sin_i,
    output pdh_pkg::sample_t i_o,
    output pdh_pkg::sample_t q_o
);
    import pdh_pkg::*;

    logic signed [31:0] i_full_w, q_full_w;
    logic signed [31:0] i_shift_w, q_shift_w;

    ////////////////////////////////////////////////////////////
    // Rotation by the active angle
    ////////////////////////////////////////////////////////////
    always_comb begin
        i_full_w  = rot_cos_i * a_i - rot_sin_i * b_i;
        q_full_w  = rot_sin_i * a_i + rot_cos_i * b_i;
        i_shift_w = i_full_w >>> COEFF_SHIFT;  // Drop Q15 fraction
        q_shift_w = q_full_w >>> COEFF_SHIFT;
    end

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            i_o <= '0;
            q_o <= '0;
        end else begin
            i_o <= i_shift_w[15:0];
            q_o <= q_shift_w[15:0];
        end
    end

endmodule

//--- readback_mux.sv
`timescale 1ns/1ps

module readback_mux (
    input  logic                clk,
    input  logic                rst_i,
    input  pdh_pkg::cmd_t       cmd_i,
    input  pdh_pkg::cmd_data_t  data_i,
    input  pdh_pkg::adc_raw_t   adc_a_i,
    input  pdh_pkg::adc_raw_t   adc_b_i,
    input  pdh_pkg::sample_t    a_s_i,
    input  pdh_pkg::sample_t    b_s_i,
    input  pdh_pkg::sample_t    sin_i,
    input  pdh_pkg::sample_t    cos_i,
    input  pdh_pkg::sample_t    rot_sin_i,
    input  pdh_pkg::sample_t    rot_cos_i,
    input  pdh_pkg::sample_t    i_i,
    input  pdh_pkg::sample_t    q_i,
    input  pdh_pkg::led_t       led_i,
    input  pdh_pkg::dac_code_t  dac_dat_i,
    input  logic                dac_sel_i,
    input  logic                dac_wrt_i,
    output pdh_pkg::gpio_word_t callback_o
);
    import pdh_pkg::*;

    cs_sel_t               cs_sel_w;
    sample_t               cs_val_w;
    logic [CB_CMD_LSB-1:0] payload_w;
    logic                  echo_w;
    gpio_word_t            callback_w;

    assign cs_sel_w = data_i[CS_SEL_W-1:0];

    ////////////////////////////////////////////////////////////
    // CHECK_SIGNED value select
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (cs_sel_w)
            5'd0:    cs_val_w = a_s_i;
            5'd1:    cs_val_w = b_s_i;
            5'd2:    cs_val_w = cos_i;      // Staged pair
            5'd3:    cs_val_w = sin_i;
            5'd4:    cs_val_w = rot_cos_i;  // Active pair
            5'd5:    cs_val_w = rot_sin_i;
            5'd6:    cs_val_w = i_i;
            5'd7:    cs_val_w = q_i;
            default: cs_val_w = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Callback payload per command
    ////////////////////////////////////////////////////////////
    always_comb begin
        payload_w = '0;
        echo_w    = 1'b1;
        case (cmd_i)
            CMD_SET_LED: payload_w[7:0] = led_i;
            CMD_SET_DAC: payload_w[15:0] = {dac_wrt_i, dac_sel_i, dac_dat_i};
            CMD_GET_ADC: payload_w = {adc_b_i, adc_a_i};
            CMD_CHECK_SIGNED: payload_w[20:0] = {cs_sel_w, cs_val_w};
            CMD_SET_ROT_COEFFS: payload_w = {sin_i[15:2], cos_i[15:2]};
            CMD_COMMIT_ROT_COEFFS: payload_w = {q_i[15:2], i_i[15:2]};
            default: echo_w = 1'b0;  // IDLE and undefined codes read zero
        endcase
    end

    assign callback_w = echo_w ? {cmd_i, payload_w} : '0;

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            callback_o <= '0;
        end else begin
            callback_o <= callback_w;
        end
    end

endmodule

//--- pdh_core.sv
`timescale 1ns/1ps

module pdh_core #(
    parameter int unsigned SYNC_STAGES = 2
) (
    input  logic                clk,
    input  logic                rst_i,
    input  pdh_pkg::adc_raw_t   adc_dat_a_i,
    input  pdh_pkg::adc_raw_t   adc_dat_b_i,
    input  pdh_pkg::gpio_word_t axi_from_ps_i,
    output pdh_pkg::gpio_word_t axi_to_ps_o,
    output pdh_pkg::led_t       led_o,
    output pdh_pkg::dac_code_t  dac_dat_o,
    output logic                dac_sel_o,
    output logic                dac_wrt_o
);
    import pdh_pkg::*;

    cmd_t      cmd_w;
    cmd_data_t data_w;
    sample_t   a_s_w, b_s_w;
    sample_t   sin_w, cos_w;
    sample_t   rot_sin_w, rot_cos_w;
    sample_t   i_feed_w, q_feed_w;

    ////////////////////////////////////////////////////////////
    // Command path
    ////////////////////////////////////////////////////////////
    gpio_cmd_sync #(
        .SYNC_STAGES(SYNC_STAGES)
    ) u_cmd_sync (
        .clk    (clk),
        .rst_i  (rst_i),
        .gpio_i (axi_from_ps_i),
        .cmd_o  (cmd_w),
        .data_o (data_w)
    );

    cmd_regs u_cmd_regs (
        .clk       (clk),
        .rst_i     (rst_i),
        .cmd_i     (cmd_w),
        .data_i    (data_w),
        .led_o     (led_o),
        .dac_dat_o (dac_dat_o),
        .dac_sel_o (dac_sel_o),
        .dac_wrt_o (dac_wrt_o),
        .sin_o     (sin_w),
        .cos_o     (cos_w),
        .rot_sin_o (rot_sin_w),
        .rot_cos_o (rot_cos_w)
    );

    ////////////////////////////////////////////////////////////
    // Signal path, two cycles from ADC to I/Q
    ////////////////////////////////////////////////////////////
    adc_conditioner u_adc_cond (
        .clk     (clk),
        .rst_i   (rst_i),
        .adc_a_i (adc_dat_a_i),
        .adc_b_i (adc_dat_b_i),
        .a_o     (a_s_w),
        .b_o     (b_s_w)
    );

    iq_rotator u_iq_rot (
        .clk       (clk),
        .rst_i     (rst_i),
        .a_i       (a_s_w),
        .b_i       (b_s_w),
        .rot_cos_i (rot_cos_w),
        .rot_sin_i (rot_sin_w),
        .i_o       (i_feed_w),
        .q_o       (q_feed_w)
    );

    readback_mux u_readback (
        .clk        (clk),
        .rst_i      (rst_i),
        .cmd_i      (cmd_w),
        .data_i     (data_w),
        .adc_a_i    (adc_dat_a_i),
        .adc_b_i    (adc_dat_b_i),
        .a_s_i      (a_s_w),
        .b_s_i      (b_s_w),
        .sin_i      (sin_w),
        .cos_i      (cos_w),
        .rot_sin_i  (rot_sin_w),
        .rot_cos_i  (rot_cos_w),
        .i_i        (i_feed_w),
        .q_i        (q_feed_w),
        .led_i      (led_o),
        .dac_dat_i  (dac_dat_o),
        .dac_sel_i  (dac_sel_o),
        .dac_wrt_i  (dac_wrt_o),
        .callback_o (axi_to_ps_o)
    );

endmodule

//--- pdh_core_chk.sv
`timescale 1ns/1ps

module pdh_core_chk (
    input logic                clk,
    input logic                rst_i,
    input pdh_pkg::gpio_word_t callback_i,
    input pdh_pkg::dac_code_t  dac_dat_i,
    input logic                dac_sel_i,
    input logic                dac_wrt_i,
    input pdh_pkg::cmd_t       cmd_i,
    input pdh_pkg::sample_t    rot_sin_i,
    input pdh_pkg::sample_t    rot_cos_i
);
    import pdh_pkg::*;

    int unsigned      error_count = 0;
    logic [DAC_W+1:0] dac_at_rise_r;  // DAC word seen at the last rising edge

    always_ff @(posedge clk) begin
        dac_at_rise_r <= {dac_wrt_i, dac_sel_i, dac_dat_i};
    end

    a_cb_cmd: assert property (@(posedge clk) disable iff (rst_i)
        callback_i[GPIO_W-1:CB_CMD_LSB] <= 4'd6)
    else begin
        error_count++;
        $error("Callback echoes a command code above 6");
    end

    // A change at the rising edge shows up at the following falling edge
    a_dac_no_rise: assert property (@(negedge clk) disable iff (rst_i)
        {dac_wrt_i, dac_sel_i, dac_dat_i} == dac_at_rise_r)
    else begin
        error_count++;
        $error("DAC outputs changed at a rising clock edge");
    end

    a_rot_commit: assert property (@(posedge clk) disable iff (rst_i)
        !$stable({rot_sin_i, rot_cos_i}) |->
            $past(cmd_i == CMD_COMMIT_ROT_COEFFS || cmd_i > 4'd6))
    else begin
        error_count++;
        $error("Active rotation changed without a commit or restore");
    end

endmodule

bind pdh_core pdh_core_chk u_chk (
    .clk        (clk),
    .rst_i      (rst_i),
    .callback_i (axi_to_ps_o),
    .dac_dat_i  (dac_dat_o),
    .dac_sel_i  (dac_sel_o),
    .dac_wrt_i  (dac_wrt_o),
    .cmd_i      (cmd_w),
    .rot_sin_i  (rot_sin_w),
    .rot_cos_i  (rot_cos_w)
);

//--- tb_pdh_core.sv
`timescale 1ns/1ps

module tb_pdh_core;
    import pdh_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int N_CMDS          = 25;  // Commands issued by the sequence below
    localparam int WATCHDOG_CYCLES = N_CMDS * 20 + 200;

    logic       clk;
    logic       rst_i;
    adc_raw_t   adc_a, adc_b;
    gpio_word_t axi_from_ps, axi_to_ps;
    led_t       led;
    dac_code_t  dac_dat;
    logic       dac_sel, dac_wrt;

    // Register model of the core
    led_t       mdl_led;
    dac_code_t  mdl_dac;
    logic       mdl_sel, mdl_wrt;
    sample_t    mdl_sin, mdl_cos, mdl_rsin, mdl_rcos;
    gpio_word_t exp_word;
    event       check_ev;

    pdh_core #(
        .SYNC_STAGES(2)
    ) uut (
        .clk           (clk),
        .rst_i         (rst_i),
        .adc_dat_a_i   (adc_a),
        .adc_dat_b_i   (adc_b),
        .axi_from_ps_i (axi_from_ps),
        .axi_to_ps_o   (axi_to_ps),
        .led_o         (led),
        .dac_dat_o     (dac_dat),
        .dac_sel_o     (dac_sel),
        .dac_wrt_o     (dac_wrt)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Error handling and compare tasks
    ////////////////////////////////////////////////////////////
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input gpio_word_t got, input gpio_word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_led(input led_t got, input led_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] led_o got %h expected %h", got, exp));
        end
    endtask

    task automatic check_dac(input dac_code_t got_dat, input logic got_sel, input logic got_wrt,
                             input dac_code_t exp_dat, input logic exp_sel, input logic exp_wrt);
        if ({got_wrt, got_sel, got_dat} !== {exp_wrt, exp_sel, exp_dat}) begin
            abort_run($sformatf("[FAIL] dac_dat_o/dac_sel_o/dac_wrt_o got %h/%h/%h expected %h/%h/%h",
                                got_dat, got_sel, got_wrt, exp_dat, exp_sel, exp_wrt));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    task automatic restore_model();
        mdl_led  = '0;
        mdl_dac  = 14'h2000;
        mdl_sel  = 1'b0;
        mdl_wrt  = 1'b0;
        mdl_sin  = '0;
        mdl_cos  = 16'sh7FFF;
        mdl_rsin = '0;
        mdl_rcos = 16'sh7FFF;
    endtask

    task automatic apply_model(input logic [3:0] code, input cmd_data_t data);
        case (code)
            4'd0, 4'd3, 4'd4: begin
            end
            4'd1: mdl_led = data[7:0];
            4'd2: {mdl_wrt, mdl_sel, mdl_dac} = data[15:0];
            4'd5: begin
                if (data[16]) begin
                    mdl_sin = data[15:0];
                end else begin
                    mdl_cos = data[15:0];
                end
            end
            4'd6: begin
                mdl_rsin = mdl_sin;
                mdl_rcos = mdl_cos;
            end
            default: restore_model();
        endcase
    endtask

    function automatic gpio_word_t expect_callback(input logic [3:0] code, input cmd_data_t data);
        logic signed [31:0] a_s, b_s, i_v, q_v;
        logic [15:0]        sel_v;
        a_s = 32'sd8192 - $signed({18'd0, adc_a});  // Inverting front end
        b_s = 32'sd8192 - $signed({18'd0, adc_b});
        i_v = (mdl_rcos * a_s - mdl_rsin * b_s) >>> 15;
        q_v = (mdl_rsin * a_s + mdl_rcos * b_s) >>> 15;
        case (data[4:0])
            5'd0:    sel_v = a_s[15:0];
            5'd1:    sel_v = b_s[15:0];
            5'd2:    sel_v = mdl_cos;
            5'd3:    sel_v = mdl_sin;
            5'd4:    sel_v = mdl_rcos;
            5'd5:    sel_v = mdl_rsin;
            5'd6:    sel_v = i_v[15:0];
            5'd7:    sel_v = q_v[15:0];
            default: sel_v = '0;
        endcase
        case (code)
            4'd1:    return {code, 20'd0, mdl_led};
            4'd2:    return {code, 12'd0, mdl_wrt, mdl_sel, mdl_dac};
            4'd3:    return {code, adc_b, adc_a};
            4'd4:    return {code, 7'd0, data[4:0], sel_v};
            4'd5:    return {code, mdl_sin[15:2], mdl_cos[15:2]};
            4'd6:    return {code, q_v[15:2], i_v[15:2]};
            default: return '0;
        endcase
    endfunction

    // Strobe held 8 cycles, then low for 4 before the next command
    task automatic run_cmd(input logic [3:0] code, input cmd_data_t data);
        @(negedge clk);
        axi_from_ps = {1'b0, 1'b1, code, data};
        apply_model(code, data);
        exp_word = expect_callback(code, data);
        repeat (8) @(negedge clk);
        -> check_ev;
        axi_from_ps[STROBE_BIT] = 1'b0;
        repeat (4) @(negedge clk);
    endtask

    always @(check_ev) begin
        check_word("axi_to_ps_o", axi_to_ps, exp_word);
        check_led(led, mdl_led);
        check_dac(dac_dat, dac_sel, dac_wrt, mdl_dac, mdl_sel, mdl_wrt);
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("Watchdog expired before the command sequence finished");
    end

    ////////////////////////////////////////////////////////////
    // Command sequence
    ////////////////////////////////////////////////////////////
    initial begin
        clk         = 1'b0;
        rst_i       = 1'b1;
        adc_a       = '0;
        adc_b       = '0;
        axi_from_ps = '0;
        void'($urandom(89));
        restore_model();
        exp_word = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        repeat (2) @(negedge clk);
        -> check_ev;  // Reset values
        repeat (4) begin
            run_cmd(4'd1, cmd_data_t'($urandom));
            run_cmd(4'd2, cmd_data_t'($urandom));
        end
        adc_a = adc_raw_t'($urandom);
        adc_b = adc_raw_t'($urandom);
        run_cmd(4'd3, '0);
        run_cmd(4'd4, 26'd0);
        run_cmd(4'd4, 26'd1);
        run_cmd(4'd5, {9'd0, 1'b1, 16'($urandom)});
        run_cmd(4'd5, {9'd0, 1'b0, 16'($urandom)});
        run_cmd(4'd4, 26'd6);  // Still the old rotation
        run_cmd(4'd4, 26'd7);
        run_cmd(4'd6, '0);
        for (int sel = 4; sel < 8; sel++) begin
            run_cmd(4'd4, cmd_data_t'(sel));
        end
        run_cmd(4'd9, cmd_data_t'($urandom));
        for (int sel = 2; sel < 6; sel++) begin
            run_cmd(4'd4, cmd_data_t'(sel));
        end
        if (uut.u_chk.error_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            abort_run("Assertions in the checker failed during the run");
        end
    end

endmodule

//--- sim.f
pdh_pkg.sv
gpio_cmd_sync.sv
cmd_regs.sv
adc_conditioner.sv
iq_rotator.sv
readback_mux.sv
pdh_core.sv
pdh_core_chk.sv
tb_pdh_core.sv

//--- Bender.yml
package:
  name: pdh_core

sources:
  - pdh_pkg.sv
  - gpio_cmd_sync.sv
  - cmd_regs.sv
  - adc_conditioner.sv
  - iq_rotator.sv
  - readback_mux.sv
  - pdh_core.sv
  - target: test
    files:
      - pdh_core_chk.sv
      - tb_pdh_core.sv
